// File: design/dircc_types_pkg.sv
package dircc_types_pkg;

    // Stream geometry
    localparam int data_width       = 32;
    localparam int beats_per_packet = 4;
    localparam int beat_index_width = $clog2(beats_per_packet);
    localparam int symbol_width     = 8;
    localparam int empty_width      = 2;   // Always zero on full words

    localparam int hw_addr_width = 16;
    localparam int port_width    = 8;
    localparam int sw_addr_width = data_width - hw_addr_width - port_width;

    localparam int lamport_width = 32;
    localparam int user_width    = 16;

    // Beat order within a packet
    localparam logic [beat_index_width-1:0] beat_dest    = 0;
    localparam logic [beat_index_width-1:0] beat_src     = 1;
    localparam logic [beat_index_width-1:0] beat_lamport = 2;
    localparam logic [beat_index_width-1:0] beat_payload = 3;

    // Address word of beats 0 and 1, node address in the top half
    typedef struct packed {
        logic [hw_addr_width-1:0] hw_addr;
        logic [sw_addr_width-1:0] sw_addr;
        logic [port_width-1:0]    port;
    } address_t;

endpackage

// File: design/dircc_app_pkg.sv
package dircc_app_pkg;

    import dircc_types_pkg::*;

    localparam int state_width = 4;

    typedef enum logic [state_width-1:0] {
        state_booted   = 4'd0,
        state_running  = 4'd1,
        state_stopped  = 4'd2,
        state_disabled = 4'd3
    } dircc_state_t;

    localparam logic [state_width-1:0] state_error = 4'b1000;  // OR-ed onto current state

    // Which handler produced a state write
    typedef enum logic [1:0] {
        handler_none,
        handler_receive,
        handler_send
    } handler_t;

    // Host register port
    localparam int mem_address_width = 4;
    localparam int mem_width         = 32;

    localparam logic [mem_address_width-1:0] reg_state   = 4'd0;
    localparam logic [mem_address_width-1:0] reg_user    = 4'd1;
    localparam logic [mem_address_width-1:0] reg_lamport = 4'd2;

    localparam logic [hw_addr_width-1:0] node_address = 16'h0042;

    // Fan-out of port 0, sent in table order
    localparam int num_targets        = 3;
    localparam int target_index_width = $clog2(num_targets);

    localparam logic [hw_addr_width-1:0] target_table [num_targets] = '{
        16'h0101,
        16'h0102,
        16'h0203
    };

endpackage

// File: design/dircc_packet_receiver.sv
`timescale 1ns/1ps

module dircc_packet_receiver
    import dircc_types_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic [data_width-1:0]    input_data,
    input  logic [empty_width-1:0]   input_empty,
    input  logic                     input_startofpacket,
    input  logic                     input_endofpacket,
    input  logic                     input_valid,
    output logic                     input_ready,

    input  logic                     packet_taken,
    output logic                     packet_valid,
    output logic [data_width-1:0]    packet_dest,
    output logic [data_width-1:0]    packet_src,
    output logic [lamport_width-1:0] packet_lamport,
    output logic [data_width-1:0]    packet_payload
);

    logic [beat_index_width-1:0] beat_cnt;
    logic [beat_index_width-1:0] beat_idx;
    logic                        accept;
    logic [data_width-1:0]       beat_data;

    assign input_ready = !packet_valid;   // Held packet blocks the stream
    assign accept      = input_valid && input_ready;
    assign beat_idx    = input_startofpacket ? beat_dest : beat_cnt;

    // Empty symbols sit at the low end of the last beat
    assign beat_data = input_endofpacket ?
        (input_data & ({data_width{1'b1}} << (symbol_width * input_empty))) : input_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt     <= '0;
            packet_valid <= 1'b0;
        end else begin
            if (packet_taken) begin
                packet_valid <= 1'b0;
            end
            if (accept) begin
                beat_cnt <= input_endofpacket ? beat_dest : beat_idx + 1'b1;
                if (input_endofpacket) begin
                    packet_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (beat_idx)
                beat_dest:    packet_dest    <= beat_data;
                beat_src:     packet_src     <= beat_data;
                beat_lamport: packet_lamport <= beat_data;
                default:      packet_payload <= beat_data;
            endcase
        end
    end

endmodule

// File: design/dircc_processing.sv
`timescale 1ns/1ps

module dircc_processing
    import dircc_types_pkg::*, dircc_app_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     packet_valid,
    input  logic [data_width-1:0]    packet_dest,
    input  logic [data_width-1:0]    packet_src,
    input  logic [lamport_width-1:0] packet_lamport,
    input  logic [data_width-1:0]    packet_payload,
    output logic                     packet_taken,

    output logic                     write_packet,
    output logic [hw_addr_width-1:0] out_dest,
    output logic [lamport_width-1:0] out_lamport,
    output logic [user_width-1:0]    out_payload,
    input  logic                     sending,

    input  logic [state_width-1:0]   cur_state,
    output logic                     state_write,
    output logic [state_width-1:0]   state_next,
    output logic [user_width-1:0]    user_next,
    output logic [lamport_width-1:0] lamport_next
);

    handler_t                      handler;
    logic [lamport_width-1:0]      lamport;
    logic [user_width-1:0]         user_state;
    logic [target_index_width-1:0] target_idx;
    dircc_state_t                  base_state;
    logic [lamport_width-1:0]      lamport_recv;
    logic                          issue;
    logic                          last_target;

    assign base_state   = dircc_state_t'(cur_state & ~state_error);
    assign lamport_recv = ((packet_lamport > lamport) ? packet_lamport : lamport) + 1'b1;

    // One packet per target, sender must be idle
    assign issue       = (handler == handler_send) && !sending && !write_packet;
    assign last_target = (target_idx == target_index_width'(num_targets - 1));

    assign user_next    = user_state;
    assign lamport_next = lamport;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            handler      <= handler_none;
            lamport      <= '0;
            user_state   <= '0;
            target_idx   <= '0;
            packet_taken <= 1'b0;
            state_write  <= 1'b0;
            state_next   <= state_booted;
            write_packet <= 1'b0;
        end else begin
            packet_taken <= 1'b0;
            state_write  <= 1'b0;
            write_packet <= 1'b0;

            case (handler)
                handler_none: begin
                    // BOOTED leaves the packet waiting
                    if (packet_valid && !packet_taken) begin
                        if (base_state == state_running) begin
                            lamport      <= lamport_recv;
                            user_state   <= user_state + packet_payload[user_width-1:0];
                            state_next   <= cur_state;
                            state_write  <= 1'b1;
                            packet_taken <= 1'b1;
                            handler      <= handler_receive;
                        end else if (base_state == state_stopped ||
                                     base_state == state_disabled) begin
                            state_next   <= cur_state | state_error;   // Swallowed
                            state_write  <= 1'b1;
                            packet_taken <= 1'b1;
                        end
                    end
                end

                handler_receive: begin
                    lamport     <= lamport + 1'b1;   // Send event
                    state_next  <= cur_state;
                    state_write <= 1'b1;
                    target_idx  <= '0;
                    handler     <= handler_send;
                end

                handler_send: begin
                    if (issue) begin
                        write_packet <= 1'b1;
                        if (last_target) begin
                            handler <= handler_none;
                        end else begin
                            target_idx <= target_idx + 1'b1;
                        end
                    end
                end

                default: handler <= handler_none;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_dest    <= target_table[target_idx];
            out_lamport <= lamport;
            out_payload <= user_state;
        end
    end

endmodule

// File: design/dircc_packet_sender.sv
`timescale 1ns/1ps

module dircc_packet_sender
    import dircc_types_pkg::*, dircc_app_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     write_packet,
    input  logic [hw_addr_width-1:0] out_dest,
    input  logic [lamport_width-1:0] out_lamport,
    input  logic [user_width-1:0]    out_payload,
    output logic                     sending,

    output logic [data_width-1:0]    output_data,
    output logic [empty_width-1:0]   output_empty,
    output logic                     output_startofpacket,
    output logic                     output_endofpacket,
    output logic                     output_valid,
    input  logic                     output_ready
);

    address_t                    dest_word;
    address_t                    src_word;
    logic [lamport_width-1:0]    lamport_word;
    logic [user_width-1:0]       payload_word;
    logic [beat_index_width-1:0] beat;

    assign src_word = '{hw_addr: node_address, sw_addr: '0, port: '0};   // Port 0 only

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            output_valid <= 1'b0;
            beat         <= beat_dest;
        end else if (write_packet) begin
            output_valid <= 1'b1;
            beat         <= beat_dest;
        end else if (output_valid && output_ready) begin
            if (beat == beat_payload) begin
                output_valid <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_packet) begin
            dest_word    <= '{hw_addr: out_dest, sw_addr: '0, port: '0};
            lamport_word <= out_lamport;
            payload_word <= out_payload;
        end
    end

    always_comb begin
        case (beat)
            beat_dest:    output_data = dest_word;
            beat_src:     output_data = src_word;
            beat_lamport: output_data = lamport_word;
            default:      output_data = {{(data_width - user_width){1'b0}}, payload_word};
        endcase
    end

    assign output_startofpacket = output_valid && (beat == beat_dest);
    assign output_endofpacket   = output_valid && (beat == beat_payload);
    assign output_empty         = '0;

    assign sending = write_packet || output_valid;   // Busy until last beat leaves

endmodule

// File: design/dircc_status_register.sv
`timescale 1ns/1ps

module dircc_status_register
    import dircc_types_pkg::*, dircc_app_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,

    input  logic [mem_address_width-1:0] mem_address,
    input  logic                         mem_write,
    input  logic [mem_width-1:0]         mem_writedata,
    output logic [mem_width-1:0]         mem_readdata,

    input  logic                         state_write,
    input  logic [state_width-1:0]       state_next,
    input  logic [user_width-1:0]        user_next,
    input  logic [lamport_width-1:0]     lamport_next,
    output logic [state_width-1:0]       cur_state
);

    logic [user_width-1:0]    user_state;
    logic [lamport_width-1:0] lamport;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_state  <= state_booted;
            user_state <= '0;
            lamport    <= '0;
        end else if (state_write) begin
            // Handler update wins over the host
            cur_state  <= state_next;
            user_state <= user_next;
            lamport    <= lamport_next;
        end else if (mem_write && mem_address == reg_state) begin
            cur_state <= mem_writedata[state_width-1:0];   // User and Lamport read only
        end
    end

    always_ff @(posedge clk) begin
        case (mem_address)
            reg_state:   mem_readdata <= mem_width'(cur_state);
            reg_user:    mem_readdata <= mem_width'(user_state);
            reg_lamport: mem_readdata <= mem_width'(lamport);
            default:     mem_readdata <= '0;
        endcase
    end

endmodule

// File: design/dircc_node.sv
`timescale 1ns/1ps

module dircc_node
    import dircc_types_pkg::*, dircc_app_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,

    input  logic [data_width-1:0]        input_data,
    input  logic [empty_width-1:0]       input_empty,
    input  logic                         input_startofpacket,
    input  logic                         input_endofpacket,
    input  logic                         input_valid,
    output logic                         input_ready,

    output logic [data_width-1:0]        output_data,
    output logic [empty_width-1:0]       output_empty,
    output logic                         output_startofpacket,
    output logic                         output_endofpacket,
    output logic                         output_valid,
    input  logic                         output_ready,

    input  logic [mem_address_width-1:0] mem_address,
    input  logic                         mem_write,
    input  logic [mem_width-1:0]         mem_writedata,
    output logic [mem_width-1:0]         mem_readdata
);

    // Receiver to processing
    logic                     packet_valid;
    logic                     packet_taken;
    logic [data_width-1:0]    packet_dest;
    logic [data_width-1:0]    packet_src;
    logic [lamport_width-1:0] packet_lamport;
    logic [data_width-1:0]    packet_payload;

    // Processing to sender
    logic                     write_packet;
    logic                     sending;
    logic [hw_addr_width-1:0] out_dest;
    logic [lamport_width-1:0] out_lamport;
    logic [user_width-1:0]    out_payload;

    // Processing to status register
    logic                     state_write;
    logic [state_width-1:0]   state_next;
    logic [user_width-1:0]    user_next;
    logic [lamport_width-1:0] lamport_next;
    logic [state_width-1:0]   cur_state;

    dircc_packet_receiver u_receiver (
        .clk                 (clk),
        .reset_n             (reset_n),
        .input_data          (input_data),
        .input_empty         (input_empty),
        .input_startofpacket (input_startofpacket),
        .input_endofpacket   (input_endofpacket),
        .input_valid         (input_valid),
        .input_ready         (input_ready),
        .packet_taken        (packet_taken),
        .packet_valid        (packet_valid),
        .packet_dest         (packet_dest),
        .packet_src          (packet_src),
        .packet_lamport      (packet_lamport),
        .packet_payload      (packet_payload)
    );

    dircc_processing u_processing (
        .clk            (clk),
        .reset_n        (reset_n),
        .packet_valid   (packet_valid),
        .packet_dest    (packet_dest),
        .packet_src     (packet_src),
        .packet_lamport (packet_lamport),
        .packet_payload (packet_payload),
        .packet_taken   (packet_taken),
        .write_packet   (write_packet),
        .out_dest       (out_dest),
        .out_lamport    (out_lamport),
        .out_payload    (out_payload),
        .sending        (sending),
        .cur_state      (cur_state),
        .state_write    (state_write),
        .state_next     (state_next),
        .user_next      (user_next),
        .lamport_next   (lamport_next)
    );

    dircc_packet_sender u_sender (
        .clk                  (clk),
        .reset_n              (reset_n),
        .write_packet         (write_packet),
        .out_dest             (out_dest),
        .out_lamport          (out_lamport),
        .out_payload          (out_payload),
        .sending              (sending),
        .output_data          (output_data),
        .output_empty         (output_empty),
        .output_startofpacket (output_startofpacket),
        .output_endofpacket   (output_endofpacket),
        .output_valid         (output_valid),
        .output_ready         (output_ready)
    );

    dircc_status_register u_status (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_address   (mem_address),
        .mem_write     (mem_write),
        .mem_writedata (mem_writedata),
        .mem_readdata  (mem_readdata),
        .state_write   (state_write),
        .state_next    (state_next),
        .user_next     (user_next),
        .lamport_next  (lamport_next),
        .cur_state     (cur_state)
    );

endmodule

// File: tests/dircc_node_checker.sv
`timescale 1ns/1ps

module dircc_node_checker
    import dircc_types_pkg::*;
(
    input logic                  clk,
    input logic                  reset_n,
    input logic                  input_valid,
    input logic                  input_endofpacket,
    input logic                  input_ready,
    input logic                  packet_valid,
    input logic                  output_valid,
    input logic                  output_ready,
    input logic [data_width-1:0] output_data,
    input logic                  output_startofpacket,
    input logic                  output_endofpacket
);

    int assert_fails = 0;

    // Stalled beat keeps valid and data
    hold_beat: assert property (@(posedge clk) disable iff (!reset_n)
        output_valid && !output_ready |=> output_valid && $stable(output_data))
        else begin
            assert_fails++;
            $error("output beat changed while output_ready was low");
        end

    one_beat_framing: assert property (@(posedge clk) disable iff (!reset_n)
        !(output_startofpacket && output_endofpacket))
        else begin
            assert_fails++;
            $error("startofpacket and endofpacket on the same beat");
        end

    // Last input beat leaves the receiver full
    held_packet_blocks: assert property (@(posedge clk) disable iff (!reset_n)
        input_valid && input_ready && input_endofpacket |=> packet_valid && !input_ready)
        else begin
            assert_fails++;
            $error("packet not held with input_ready low after its last beat");
        end

endmodule

bind dircc_node dircc_node_checker u_checker (
    .clk                  (clk),
    .reset_n              (reset_n),
    .input_valid          (input_valid),
    .input_endofpacket    (input_endofpacket),
    .input_ready          (input_ready),
    .packet_valid         (packet_valid),
    .output_valid         (output_valid),
    .output_ready         (output_ready),
    .output_data          (output_data),
    .output_startofpacket (output_startofpacket),
    .output_endofpacket   (output_endofpacket)
);

// File: tests/dircc_node_tb.sv
`timescale 1ns/1ps

module dircc_node_tb
    import dircc_types_pkg::*, dircc_app_pkg::*;
();

    localparam int num_packets   = 20;
    localparam int stop_packets  = 3;
    localparam int total_packets = 2 * num_packets + stop_packets;
    // Three packets of four beats, each beat stalled a few cycles at worst
    localparam int cycles_per_packet = num_targets * beats_per_packet * 8 + 32;
    localparam int timeout_cycles    = total_packets * cycles_per_packet + 500;
    localparam logic [hw_addr_width-1:0] remote_node = 16'h0105;

    logic                         clk;
    logic                         reset_n;
    logic [data_width-1:0]        input_data;
    logic [empty_width-1:0]       input_empty;
    logic                         input_startofpacket;
    logic                         input_endofpacket;
    logic                         input_valid;
    logic                         input_ready;
    logic [data_width-1:0]        output_data;
    logic [empty_width-1:0]       output_empty;
    logic                         output_startofpacket;
    logic                         output_endofpacket;
    logic                         output_valid;
    logic                         output_ready;
    logic [mem_address_width-1:0] mem_address;
    logic                         mem_write;
    logic [mem_width-1:0]         mem_writedata;
    logic [mem_width-1:0]         mem_readdata;

    integer                   seed = 32'ha9a4617e;
    bit                       throttle = 1'b0;
    logic [data_width-1:0]    exp_q [$];   // Expected output beats in order
    logic [data_width-1:0]    ts_mem [num_packets + stop_packets];
    logic [data_width-1:0]    pay_mem [num_packets + stop_packets];
    logic [lamport_width-1:0] ref_lamport = '0;
    logic [user_width-1:0]    ref_user = '0;
    int error_count = 0;
    int check_count = 0;
    int beat_no     = 0;
    int packets_out = 0;
    int cycle_count = 0;

    dircc_node UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [data_width-1:0] address_word(input logic [hw_addr_width-1:0] hw);
        return {hw, 16'h0000};   // sw_addr and port zero
    endfunction

    // Receive event takes the larger clock plus one, send event adds one more
    function automatic logic [lamport_width-1:0] lamport_after(
        input logic [lamport_width-1:0] local_clk,
        input logic [lamport_width-1:0] pkt_ts
    );
        return ((pkt_ts > local_clk) ? pkt_ts : local_clk) + 2;
    endfunction

    task automatic predict(input logic [data_width-1:0] ts, input logic [data_width-1:0] pay);
        ref_lamport = lamport_after(ref_lamport, ts);
        ref_user    = ref_user + pay[user_width-1:0];
        for (int t = 0; t < num_targets; t++) begin
            exp_q.push_back(address_word(target_table[t]));
            exp_q.push_back(address_word(node_address));
            exp_q.push_back(ref_lamport);
            exp_q.push_back({16'h0000, ref_user});
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [mem_address_width-1:0] addr,
                             input logic [mem_width-1:0] data);
        @(negedge clk);
        mem_address   = addr;
        mem_writedata = data;
        mem_write     = 1'b1;
        @(negedge clk);
        mem_write = 1'b0;
    endtask

    task automatic read_reg(input logic [mem_address_width-1:0] addr,
                            output logic [mem_width-1:0] data);
        @(negedge clk);
        mem_address = addr;
        mem_write   = 1'b0;
        @(negedge clk);   // Registered read data
        data = mem_readdata;
    endtask

    task automatic send_packet(input logic [data_width-1:0] ts, input logic [data_width-1:0] pay);
        logic [data_width-1:0] beats [beats_per_packet];
        beats[0] = address_word(node_address);
        beats[1] = address_word(remote_node);
        beats[2] = ts;
        beats[3] = pay;
        for (int b = 0; b < beats_per_packet; b++) begin
            @(negedge clk);
            input_data          = beats[b];
            input_startofpacket = (b == 0);
            input_endofpacket   = (b == beats_per_packet - 1);
            input_valid         = 1'b1;
            while (!input_ready) @(negedge clk);
        end
        @(negedge clk);
        input_valid         = 1'b0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
    endtask

    task automatic run_traffic();
        for (int i = 0; i < num_packets; i++) begin
            predict(ts_mem[i], pay_mem[i]);
            send_packet(ts_mem[i], pay_mem[i]);
        end
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // Output sink and compare, beat is taken on the next rising edge
    always @(negedge clk) begin
        output_ready = throttle ? 1'($random(seed)) : 1'b1;
        if (reset_n && output_valid && output_ready) begin
            check_count++;
            assert (exp_q.size() != 0) else begin
                error_count++;
                $display("ERROR at %0t ns: output beat appeared with no packet expected", $time);
            end
            if (exp_q.size() != 0) begin
                check("output_data", output_data, exp_q.pop_front());
            end
            check("output_startofpacket", output_startofpacket, beat_no == 0);
            check("output_endofpacket", output_endofpacket, beat_no == beats_per_packet - 1);
            check("output_empty", output_empty, 0);
            beat_no = (beat_no + 1) % beats_per_packet;
            if (beat_no == 0) begin
                packets_out++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [mem_width-1:0] rdata;
        int                   seen;
        reset_n             = 1'b0;
        input_data          = '0;
        input_empty         = '0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
        input_valid         = 1'b0;
        output_ready        = 1'b1;
        mem_address         = '0;
        mem_write           = 1'b0;
        mem_writedata       = '0;
        for (int i = 0; i < num_packets + stop_packets; i++) begin
            ts_mem[i]  = $random(seed) & 32'h7fff_ffff;
            pay_mem[i] = $random(seed);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        read_reg(reg_state, rdata);
        check("state after reset", rdata, mem_width'(state_booted));
        read_reg(reg_user, rdata);
        check("user state after reset", rdata, 0);
        read_reg(reg_lamport, rdata);
        check("lamport after reset", rdata, 0);

        write_reg(reg_state, mem_width'(state_running));
        run_traffic();

        // Same traffic with the sink stalling about half the time
        @(posedge clk);
        throttle = 1'b1;
        run_traffic();
        @(posedge clk);
        throttle = 1'b0;

        write_reg(reg_state, mem_width'(state_stopped));
        seen = packets_out;
        for (int i = num_packets; i < num_packets + stop_packets; i++) begin
            send_packet(ts_mem[i], pay_mem[i]);
        end
        repeat (20) @(negedge clk);
        check("output packets while stopped", packets_out, seen);
        read_reg(reg_state, rdata);
        check("state while stopped", rdata, mem_width'(state_stopped | state_error));

        read_reg(reg_user, rdata);
        check("final user state", rdata, mem_width'(ref_user));
        read_reg(reg_lamport, rdata);
        check("final lamport", rdata, ref_lamport);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, UUT.u_checker.assert_fails);
        if (error_count == 0 && UUT.u_checker.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/dircc_types_pkg.sv
design/dircc_app_pkg.sv
design/dircc_packet_receiver.sv
design/dircc_processing.sv
design/dircc_packet_sender.sv
design/dircc_status_register.sv
design/dircc_node.sv
tests/dircc_node_checker.sv
tests/dircc_node_tb.sv

// File: Bender.yml
package:
  name: dircc_node

sources:
  - design/dircc_types_pkg.sv
  - design/dircc_app_pkg.sv
  - design/dircc_packet_receiver.sv
  - design/dircc_processing.sv
  - design/dircc_packet_sender.sv
  - design/dircc_status_register.sv
  - design/dircc_node.sv
  - target: test
    files:
      - tests/dircc_node_checker.sv
      - tests/dircc_node_tb.sv
